/* design/cpuCore_settings.svh */
`ifndef CPU_CORE_SETTINGS_SVH
`define CPU_CORE_SETTINGS_SVH

// data path and instruction word width
`define CPU_WORD_W 16

// memory is word addressed
`define CPU_ADDR_W 9

// general purpose registers R0..R7
// fixes the 3-bit register fields
`define CPU_NUM_REGS 8

// words behind the bus, 2**CPU_ADDR_W
`define CPU_MEM_DEPTH 512

`endif

/* design/cpuCorePkg.sv */
`include "cpuCore_settings.svh"

package cpuCorePkg;

    // basic widths
    typedef logic [`CPU_WORD_W-1:0] wordT;
    typedef logic [`CPU_ADDR_W-1:0] addrT;
    typedef logic [$clog2(`CPU_NUM_REGS)-1:0] regNumT;

    // instruction class, bits 15..13
    // 000 and 010 are not decoded
    typedef enum logic [2:0] {
        opcBranch = 3'b001,
        opcLdr    = 3'b011,
        opcStr    = 3'b100,
        opcAlu    = 3'b101,
        opcMov    = 3'b110,
        opcHalt   = 3'b111
    } opcodeT;

    // op field, bits 12..11
    typedef enum logic [1:0] {
        aluAdd = 2'b00,
        aluCmp = 2'b01,
        aluAnd = 2'b10,
        aluMvn = 2'b11
    } aluOpT;

    // shifter on the B operand
    typedef enum logic [1:0] {
        shNone = 2'b00,
        shLsl  = 2'b01,
        shLsr  = 2'b10,
        shAsr  = 2'b11
    } shiftT;

    // branch condition, sits in the Rn field
    typedef enum logic [2:0] {
        condAl = 3'b000,
        condEq = 3'b001,
        condNe = 3'b010,
        condLt = 3'b011,
        condLe = 3'b100
    } condT;

    // which instruction field names the register
    typedef enum logic [1:0] {
        selRn,
        selRd,
        selRm
    } regSelT;

    // register file write source
    typedef enum logic [1:0] {
        wbC,
        wbImm8,
        wbMem
    } wbSelT;

    // memory bus command
    typedef enum logic [1:0] {
        memNone  = 2'b00,
        memWrite = 2'b01,
        memRead  = 2'b10
    } memCmdT;

    // one state per instruction step
    typedef enum logic [4:0] {
        stReset,
        stIf1,
        stIf2,
        stUpdPc,
        stDecode,
        stMovImm,
        stMovB,
        stMovOp,
        stLoadA,
        stLoadB,
        stAluOp,
        stWriteC,
        stMemSum,
        stMemAddr,
        stLdrRd1,
        stLdrRd2,
        stLdrWr,
        stStrB,
        stStrCopy,
        stStrWr,
        stBranch,
        stHalt
    } ctrlStateT;

endpackage

/* design/instrDecoder.sv */
`include "cpuCore_settings.svh"

module instrDecoder import cpuCorePkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  wordT        readData,
    input  logic        loadIr,
    input  regSelT      regSel,
    output opcodeT      opcode,
    output aluOpT       op,
    output shiftT       shift,
    output condT        cond,
    output regNumT      readNum,
    output regNumT      writeNum,
    output wordT        sxImm5,
    output wordT        sxImm8,
    output logic [7:0]  imm8
);

    wordT   ir;
    regNumT regNum;

    // instruction register, fetched word lands here on loadIr
    always_ff @(posedge clk) begin
        if (loadIr) begin
            ir <= readData;
        end
    end

    // fixed field positions
    assign opcode = opcodeT'(ir[15:13]);
    assign op     = aluOpT'(ir[12:11]);
    // Rn doubles as the branch condition
    assign cond   = condT'(ir[10:8]);
    assign imm8   = ir[7:0];

    // STR reuses bits 4..3 as offset, so the stored register passes unshifted
    assign shift = (opcode == opcStr) ? shNone : shiftT'(ir[4:3]);

    // register number for both the read and the write port
    always_comb begin
        case (regSel)
            selRn:   regNum = ir[10:8];
            selRm:   regNum = ir[2:0];
            default: regNum = ir[7:5];
        endcase
    end

    assign readNum  = regNum;
    assign writeNum = regNum;

    // sign extension
    assign sxImm8 = {{(`CPU_WORD_W-8){ir[7]}}, ir[7:0]};
    assign sxImm5 = {{(`CPU_WORD_W-5){ir[4]}}, ir[4:0]};

    // controller always names a register field
    regSelKnown: assert property (@(posedge clk) disable iff (!arstN)
        !$isunknown(regSel));

endmodule

/* design/controlFsm.sv */
module controlFsm import cpuCorePkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  opcodeT  opcode,
    input  aluOpT   op,
    output logic    loadIr,
    output regSelT  regSel,
    output logic    loadA,
    output logic    loadB,
    output logic    loadC,
    output logic    loadStatus,
    output logic    aSel,
    output logic    bSel,
    output wbSelT   wbSel,
    output logic    regWrite,
    output logic    loadPc,
    output logic    clearPc,
    output logic    loadAddr,
    output logic    addrSel,
    output memCmdT  memCmd,
    output logic    halted
);

    ctrlStateT state;
    ctrlStateT nextState;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stReset;
        end else begin
            state <= nextState;
        end
    end

    // next state and outputs from one table
    always_comb begin
        nextState  = stReset;
        loadIr     = 1'b0;
        regSel     = selRd;
        loadA      = 1'b0;
        loadB      = 1'b0;
        loadC      = 1'b0;
        loadStatus = 1'b0;
        aSel       = 1'b0;
        bSel       = 1'b0;
        wbSel      = wbC;
        regWrite   = 1'b0;
        loadPc     = 1'b0;
        clearPc    = 1'b0;
        loadAddr   = 1'b0;
        // data address unless a fetch step says otherwise
        addrSel    = 1'b0;
        memCmd     = memNone;
        halted     = 1'b0;
        case (state)
            // first fetch starts at address 0
            stReset: begin
                clearPc   = 1'b1;
                nextState = stIf1;
            end
            // fetch: address out
            stIf1: begin
                addrSel   = 1'b1;
                memCmd    = memRead;
                nextState = stIf2;
            end
            // fetch: latch instruction
            stIf2: begin
                addrSel   = 1'b1;
                memCmd    = memRead;
                loadIr    = 1'b1;
                nextState = stUpdPc;
            end
            // PC steps by one while it is the address source
            stUpdPc: begin
                addrSel   = 1'b1;
                loadPc    = 1'b1;
                nextState = stDecode;
            end
            stDecode: begin
                case (opcode)
                    // MOV: op 10 immediate, op 00 register
                    opcMov: begin
                        if (op == 2'b10) begin
                            nextState = stMovImm;
                        end else if (op == 2'b00) begin
                            nextState = stMovB;
                        end else begin
                            nextState = stIf1;
                        end
                    end
                    opcAlu:    nextState = stLoadA;
                    opcLdr:    nextState = (op == 2'b00) ? stLoadA : stIf1;
                    opcStr:    nextState = (op == 2'b00) ? stLoadA : stIf1;
                    opcBranch: nextState = (op == 2'b00) ? stBranch : stIf1;
                    opcHalt:   nextState = stHalt;
                    default:   nextState = stIf1;
                endcase
            end
            // Rn <- sign-extended imm8
            stMovImm: begin
                regSel    = selRn;
                wbSel     = wbImm8;
                regWrite  = 1'b1;
                nextState = stIf1;
            end
            stMovB: begin
                regSel    = selRm;
                loadB     = 1'b1;
                nextState = stMovOp;
            end
            // zero plus shifted Rm, op 00 is ADD
            stMovOp: begin
                aSel      = 1'b1;
                loadC     = 1'b1;
                nextState = stWriteC;
            end
            // base or first operand, shared by ALU and memory ops
            stLoadA: begin
                regSel    = selRn;
                loadA     = 1'b1;
                nextState = (opcode == opcAlu) ? stLoadB : stMemSum;
            end
            stLoadB: begin
                regSel    = selRm;
                loadB     = 1'b1;
                nextState = stAluOp;
            end
            // flags follow every ALU op, CMP stops here
            stAluOp: begin
                loadC      = 1'b1;
                loadStatus = 1'b1;
                nextState  = (op == aluCmp) ? stIf1 : stWriteC;
            end
            stWriteC: begin
                regSel    = selRd;
                wbSel     = wbC;
                regWrite  = 1'b1;
                nextState = stIf1;
            end
            // Rn + sxImm5
            stMemSum: begin
                bSel      = 1'b1;
                loadC     = 1'b1;
                nextState = stMemAddr;
            end
            stMemAddr: begin
                loadAddr  = 1'b1;
                nextState = (opcode == opcLdr) ? stLdrRd1 : stStrB;
            end
            stLdrRd1: begin
                memCmd    = memRead;
                nextState = stLdrRd2;
            end
            stLdrRd2: begin
                memCmd    = memRead;
                nextState = stLdrWr;
            end
            // memory word into Rd
            stLdrWr: begin
                memCmd    = memRead;
                regSel    = selRd;
                wbSel     = wbMem;
                regWrite  = 1'b1;
                nextState = stIf1;
            end
            stStrB: begin
                regSel    = selRd;
                loadB     = 1'b1;
                nextState = stStrCopy;
            end
            // C <- Rd, which drives writeData
            stStrCopy: begin
                aSel      = 1'b1;
                loadC     = 1'b1;
                nextState = stStrWr;
            end
            stStrWr: begin
                memCmd    = memWrite;
                nextState = stIf1;
            end
            // addrSel low, so pcUnit applies the branch target
            stBranch: begin
                loadPc    = 1'b1;
                nextState = stIf1;
            end
            // parked until reset
            stHalt: begin
                halted    = 1'b1;
                nextState = stHalt;
            end
            default: nextState = stReset;
        endcase
    end

    stateKnown: assert property (@(posedge clk) disable iff (!arstN)
        !$isunknown(state));

endmodule

/* design/datapath.sv */
`include "cpuCore_settings.svh"

module datapath import cpuCorePkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  regNumT  readNum,
    input  regNumT  writeNum,
    input  logic    regWrite,
    input  wbSelT   wbSel,
    input  wordT    sxImm8,
    input  wordT    sxImm5,
    input  wordT    readData,
    input  logic    loadA,
    input  logic    loadB,
    input  logic    loadC,
    input  logic    loadStatus,
    input  logic    aSel,
    input  logic    bSel,
    input  shiftT   shift,
    input  aluOpT   op,
    output wordT    result,
    output logic    flagZ,
    output logic    flagN,
    output logic    flagV
);

    localparam int MSB = `CPU_WORD_W - 1;

    wordT regFile [`CPU_NUM_REGS];
    wordT wbData;
    wordT aReg;
    wordT bReg;
    wordT cReg;
    wordT aIn;
    wordT bShifted;
    wordT bIn;
    wordT aluOut;
    logic aluV;

    // write-back source
    always_comb begin
        case (wbSel)
            wbImm8:  wbData = sxImm8;
            wbMem:   wbData = readData;
            default: wbData = cReg;
        endcase
    end

    always_ff @(posedge clk) begin
        if (regWrite) begin
            regFile[writeNum] <= wbData;
        end
    end

    // operand and result registers
    always_ff @(posedge clk) begin
        if (loadA) begin
            aReg <= regFile[readNum];
        end
        if (loadB) begin
            bReg <= regFile[readNum];
        end
        if (loadC) begin
            cReg <= aluOut;
        end
    end

    // shifter on B only
    always_comb begin
        case (shift)
            shLsl:   bShifted = {bReg[MSB-1:0], 1'b0};
            shLsr:   bShifted = {1'b0, bReg[MSB:1]};
            shAsr:   bShifted = {bReg[MSB], bReg[MSB:1]};
            default: bShifted = bReg;
        endcase
    end

    // aSel zeroes A for moves, bSel picks the offset
    assign aIn = aSel ? '0 : aReg;
    assign bIn = bSel ? sxImm5 : bShifted;

    always_comb begin
        aluV = 1'b0;
        case (op)
            aluAdd: begin
                aluOut = aIn + bIn;
                // same-sign inputs, result sign flipped
                aluV   = (aIn[MSB] == bIn[MSB]) && (aluOut[MSB] != aIn[MSB]);
            end
            aluCmp: begin
                aluOut = aIn - bIn;
                // opposite-sign inputs, result sign differs from A
                aluV   = (aIn[MSB] != bIn[MSB]) && (aluOut[MSB] != aIn[MSB]);
            end
            aluAnd:  aluOut = aIn & bIn;
            default: aluOut = ~bIn;
        endcase
    end

    // status register Z N V
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            flagZ <= 1'b0;
            flagN <= 1'b0;
            flagV <= 1'b0;
        end else if (loadStatus) begin
            flagZ <= (aluOut == '0);
            flagN <= aluOut[MSB];
            flagV <= aluV;
        end
    end

    // C is both the store data and the address source
    assign result = cReg;

    // a write must carry fully driven data from C, imm8 or memory
    wbDataKnown: assert property (@(posedge clk) disable iff (!arstN)
        regWrite |-> !$isunknown(wbData));

endmodule

/* design/pcUnit.sv */
`include "cpuCore_settings.svh"

module pcUnit import cpuCorePkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  logic        loadPc,
    input  logic        clearPc,
    input  logic        loadAddr,
    input  logic        addrSel,
    input  opcodeT      opcode,
    input  condT        cond,
    input  logic [7:0]  imm8,
    input  wordT        result,
    input  logic        flagZ,
    input  logic        flagN,
    input  logic        flagV,
    output addrT        memAddr
);

    addrT pc;
    addrT nextPc;
    addrT dataAddr;
    addrT branchOffset;
    logic taken;

    assign branchOffset = {{(`CPU_ADDR_W-8){imm8[7]}}, imm8};

    // condition check on the latched flags
    always_comb begin
        case (cond)
            condAl:  taken = 1'b1;
            condEq:  taken = flagZ;
            condNe:  taken = !flagZ;
            condLt:  taken = flagN ^ flagV;
            condLe:  taken = (flagN ^ flagV) | flagZ;
            default: taken = 1'b0;
        endcase
    end

    // addrSel high marks the fetch increment
    // otherwise PC already points past the branch
    always_comb begin
        if (addrSel) begin
            nextPc = pc + 1'b1;
        end else if (opcode == opcBranch && taken) begin
            nextPc = pc + branchOffset;
        end else begin
            nextPc = pc;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (clearPc) begin
            pc <= '0;
        end else if (loadPc) begin
            pc <= nextPc;
        end
    end

    // data address from the low bits of C
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dataAddr <= '0;
        end else if (loadAddr) begin
            dataAddr <= result[`CPU_ADDR_W-1:0];
        end
    end

    assign memAddr = addrSel ? pc : dataAddr;

    // base plus offset must land inside memory, no bits lost in truncation
    dataAddrRange: assert property (@(posedge clk) disable iff (!arstN)
        loadAddr |-> $unsigned(result) < `CPU_MEM_DEPTH);

endmodule

/* design/cpuCore.sv */
module cpuCore import cpuCorePkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  wordT    readData,
    output memCmdT  memCmd,
    output addrT    memAddr,
    output wordT    writeData,
    output logic    halted
);

    // controller to the rest
    logic   loadIr;
    regSelT regSel;
    logic   loadA;
    logic   loadB;
    logic   loadC;
    logic   loadStatus;
    logic   aSel;
    logic   bSel;
    wbSelT  wbSel;
    logic   regWrite;
    logic   loadPc;
    logic   clearPc;
    logic   loadAddr;
    logic   addrSel;

    // decoded fields
    opcodeT     opcode;
    aluOpT      op;
    shiftT      shift;
    condT       cond;
    regNumT     readNum;
    regNumT     writeNum;
    wordT       sxImm5;
    wordT       sxImm8;
    logic [7:0] imm8;

    // status flags
    logic flagZ;
    logic flagN;
    logic flagV;

    instrDecoder instrDecoder_i (
        .clk      (clk),
        .arstN    (arstN),
        .readData (readData),
        .loadIr   (loadIr),
        .regSel   (regSel),
        .opcode   (opcode),
        .op       (op),
        .shift    (shift),
        .cond     (cond),
        .readNum  (readNum),
        .writeNum (writeNum),
        .sxImm5   (sxImm5),
        .sxImm8   (sxImm8),
        .imm8     (imm8)
    );

    controlFsm controlFsm_i (
        .clk        (clk),
        .arstN      (arstN),
        .opcode     (opcode),
        .op         (op),
        .loadIr     (loadIr),
        .regSel     (regSel),
        .loadA      (loadA),
        .loadB      (loadB),
        .loadC      (loadC),
        .loadStatus (loadStatus),
        .aSel       (aSel),
        .bSel       (bSel),
        .wbSel      (wbSel),
        .regWrite   (regWrite),
        .loadPc     (loadPc),
        .clearPc    (clearPc),
        .loadAddr   (loadAddr),
        .addrSel    (addrSel),
        .memCmd     (memCmd),
        .halted     (halted)
    );

    // C register drives both the store data and the address path
    datapath datapath_i (
        .clk        (clk),
        .arstN      (arstN),
        .readNum    (readNum),
        .writeNum   (writeNum),
        .regWrite   (regWrite),
        .wbSel      (wbSel),
        .sxImm8     (sxImm8),
        .sxImm5     (sxImm5),
        .readData   (readData),
        .loadA      (loadA),
        .loadB      (loadB),
        .loadC      (loadC),
        .loadStatus (loadStatus),
        .aSel       (aSel),
        .bSel       (bSel),
        .shift      (shift),
        .op         (op),
        .result     (writeData),
        .flagZ      (flagZ),
        .flagN      (flagN),
        .flagV      (flagV)
    );

    pcUnit pcUnit_i (
        .clk      (clk),
        .arstN    (arstN),
        .loadPc   (loadPc),
        .clearPc  (clearPc),
        .loadAddr (loadAddr),
        .addrSel  (addrSel),
        .opcode   (opcode),
        .cond     (cond),
        .imm8     (imm8),
        .result   (writeData),
        .flagZ    (flagZ),
        .flagN    (flagN),
        .flagV    (flagV),
        .memAddr  (memAddr)
    );

endmodule

/* bench/cpuModel.svh */
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// one-bit shift of the second operand, code from bits 4..3
function automatic wordT shiftOne(input wordT x, input logic [1:0] sh);
    case (sh)
        2'b01:   return x << 1;
        2'b10:   return x >> 1;
        2'b11:   return wordT'($signed(x) >>> 1);
        default: return x;
    endcase
endfunction

// signed compare conditions on the flags of the last ALU op
function automatic bit condHolds(input logic [2:0] c, input bit z, input bit n, input bit v);
    case (c)
        3'd0:    return 1'b1;
        3'd1:    return z;
        3'd2:    return !z;
        3'd3:    return n != v;
        3'd4:    return z || (n != v);
        default: return 1'b0;
    endcase
endfunction

// instruction-level run of image, fills modelMem and the store list
// returns the instruction count up to and including HALT, -1 if none
function automatic int runModel();
    wordT regs [`CPU_NUM_REGS];
    wordT ir;
    wordT opA;
    wordT opB;
    wordT res;
    wordT ea;
    logic [1:0] fop;
    addrT pc;
    int exact;
    int steps;
    bit z;
    bit n;
    bit v;
    modelMem = image;
    expCount = 0;
    pc = '0;
    z = 1'b0;
    n = 1'b0;
    v = 1'b0;
    for (steps = 1; steps <= 4096; steps++) begin
        ir = modelMem[pc];
        pc = pc + 1'b1;
        fop = ir[12:11];
        case (ir[15:13])
            // MOV immediate into Rn, MOV shifted Rm into Rd
            3'b110: begin
                if (fop == 2'b10) begin
                    regs[ir[10:8]] = wordT'($signed(ir[7:0]));
                end else if (fop == 2'b00) begin
                    regs[ir[7:5]] = shiftOne(regs[ir[2:0]], ir[4:3]);
                end
            end
            3'b101: begin
                opA = regs[ir[10:8]];
                opB = shiftOne(regs[ir[2:0]], ir[4:3]);
                // exact signed value, overflow when out of 16-bit range
                exact = 0;
                case (fop)
                    2'b00: begin
                        res = opA + opB;
                        exact = int'($signed(opA)) + int'($signed(opB));
                    end
                    2'b01: begin
                        res = opA - opB;
                        exact = int'($signed(opA)) - int'($signed(opB));
                    end
                    2'b10:   res = opA & opB;
                    default: res = ~opB;
                endcase
                z = (res == '0);
                n = res[15];
                v = (exact > 32767) || (exact < -32768);
                // CMP only sets flags
                if (fop != 2'b01) begin
                    regs[ir[7:5]] = res;
                end
            end
            3'b011, 3'b100: begin
                if (fop == 2'b00) begin
                    ea = regs[ir[10:8]] + wordT'($signed(ir[4:0]));
                    if (ir[15:13] == 3'b011) begin
                        regs[ir[7:5]] = modelMem[ea[`CPU_ADDR_W-1:0]];
                    end else begin
                        modelMem[ea[`CPU_ADDR_W-1:0]] = regs[ir[7:5]];
                        expAddr[expCount] = ea[`CPU_ADDR_W-1:0];
                        expData[expCount] = regs[ir[7:5]];
                        expCount++;
                    end
                end
            end
            // pc already past the branch
            3'b001: begin
                if (fop == 2'b00 && condHolds(ir[10:8], z, n, v)) begin
                    pc = pc + addrT'($signed(ir[7:0]));
                end
            end
            3'b111:  return steps;
            default: ;
        endcase
    end
    return -1;
endfunction

`endif

/* bench/cpuCoreTb.sv */
`include "cpuCore_settings.svh"

module cpuCoreTb import cpuCorePkg::*; ();

    localparam int maxStores = 256;
    localparam int baseA = 256;
    localparam int baseB = 384;
    localparam logic [2:0] ldrOpc = 3'b011;
    localparam logic [2:0] strOpc = 3'b100;
    localparam wordT haltWord = 16'hE000;

    logic   clk;
    logic   arstN;
    logic   loadImage;
    wordT   readData;
    memCmdT memCmd;
    addrT   memAddr;
    wordT   writeData;
    logic   halted;

    wordT mem [`CPU_MEM_DEPTH];
    wordT image [`CPU_MEM_DEPTH];
    wordT modelMem [`CPU_MEM_DEPTH];
    addrT expAddr [maxStores];
    wordT expData [maxStores];
    int expCount;
    int progLen;
    int storeIdx;
    int cycles;
    int cycleLimit;
    bit haltSeen;
    bit fetchSeen;
    integer seed;

    `include "cpuModel.svh"

    cpuCore cpuCore_i (
        .clk       (clk),
        .arstN     (arstN),
        .readData  (readData),
        .memCmd    (memCmd),
        .memAddr   (memAddr),
        .writeData (writeData),
        .halted    (halted)
    );

    always #20 clk = ~clk;

    // memory answers in the same cycle, writes on the rising edge
    assign readData = mem[memAddr];

    always @(posedge clk) begin
        if (loadImage) begin
            for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
                mem[i] <= image[i];
            end
        end else if (arstN && memCmd == memWrite) begin
            mem[memAddr] <= writeData;
        end
    end

    task automatic stopRun();
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic reportMismatch(input string what);
        $display("Mismatch at time %0t: %s", $time, what);
        stopRun();
    endtask

    // bus monitor, stores compared in program order
    always @(posedge clk) begin
        if (!arstN) begin
            storeIdx = 0;
            haltSeen = 1'b0;
            fetchSeen = 1'b0;
            assert (memCmd == memNone && !halted)
            else reportMismatch("bus or halted active during reset");
        end else begin
            if (!fetchSeen && memCmd == memRead) begin
                fetchSeen = 1'b1;
                assert (memAddr == '0)
                else reportMismatch($sformatf("first fetch from %0h, expected 0", memAddr));
            end
            assert (!haltSeen || halted) else reportMismatch("halted dropped before reset");
            if (halted) begin
                haltSeen = 1'b1;
                assert (memCmd == memNone) else reportMismatch("bus command while halted");
            end
            if (memCmd == memWrite) begin
                assert (storeIdx < expCount)
                else reportMismatch($sformatf("unexpected store number %0d", storeIdx));
                assert (memAddr == expAddr[storeIdx] && writeData == expData[storeIdx])
                else reportMismatch($sformatf("store %0d wrote %h at %h, expected %h at %h",
                    storeIdx, writeData, memAddr, expData[storeIdx], expAddr[storeIdx]));
                storeIdx = storeIdx + 1;
            end
        end
    end

    // cycles since reset release
    always @(posedge clk) begin
        if (!arstN) begin
            cycles = 0;
        end else begin
            cycles = cycles + 1;
            assert (cycles <= cycleLimit) else begin
                $display("timeout: core did not halt within %0d cycles", cycleLimit);
                stopRun();
            end
        end
    end

    // instruction encoders, fields as in the instruction format
    function automatic wordT movImm(input int rn, input int imm);
        return {3'b110, 2'b10, 3'(rn), 8'(imm)};
    endfunction

    function automatic wordT movReg(input int rd, input int sh, input int rm);
        return {3'b110, 2'b00, 3'b000, 3'(rd), 2'(sh), 3'(rm)};
    endfunction

    function automatic wordT aluWord(input int op, input int rd, input int rn,
                                     input int sh, input int rm);
        return {3'b101, 2'(op), 3'(rn), 3'(rd), 2'(sh), 3'(rm)};
    endfunction

    function automatic wordT memWord(input logic [2:0] opc, input int rd, input int rn,
                                     input int off);
        return {opc, 2'b00, 3'(rn), 3'(rd), 5'(off)};
    endfunction

    function automatic wordT branchWord(input int cond, input int off);
        return {3'b001, 2'b00, 3'(cond), 8'(off)};
    endfunction

    function automatic void emit(input wordT w);
        image[progLen] = w;
        progLen++;
    endfunction

    // filler over the whole address, then R7 = 256 and R6 = 384
    task automatic newProgram();
        for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
            image[i] = wordT'(i * 16'h0139) ^ 16'hC35A;
        end
        progLen = 0;
        emit(movImm(7, 64));
        emit(movReg(7, 1, 7));
        emit(movReg(7, 1, 7));
        emit(movImm(6, 96));
        emit(movReg(6, 1, 6));
        emit(movReg(6, 1, 6));
    endtask

    task automatic buildMoves();
        newProgram();
        for (int k = 0; k < 8; k++) begin
            emit(movImm(1, $random(seed)));
            // every shift kind once, then random codes
            emit(movReg(2, (k < 4) ? k : ($random(seed) & 3), 1));
            emit(memWord(strOpc, 1, 7, k - 8));
            emit(memWord(strOpc, 2, 7, k));
        end
        emit(haltWord);
    endtask

    task automatic buildAluOps();
        newProgram();
        for (int j = 0; j < 8; j++) begin
            image[baseA + 8 + j] = wordT'($random(seed));
        end
        for (int k = 0; k < 4; k++) begin
            emit(memWord(ldrOpc, 1, 7, 8 + 2 * k));
            emit(memWord(ldrOpc, 2, 7, 9 + 2 * k));
            emit(aluWord(0, 3, 1, $random(seed) & 3, 2));
            emit(aluWord(2, 4, 1, $random(seed) & 3, 2));
            emit(aluWord(3, 5, 1, $random(seed) & 3, 2));
            emit(memWord(strOpc, 3, 7, 3 * k - 16));
            emit(memWord(strOpc, 4, 7, 3 * k - 15));
            emit(memWord(strOpc, 5, 7, 3 * k - 14));
        end
        emit(haltWord);
    endtask

    task automatic buildMemOps();
        newProgram();
        for (int j = 0; j < 8; j++) begin
            image[baseA + 8 + j] = wordT'($random(seed));
        end
        // copy through negative and positive offsets, read back each copy
        for (int k = 0; k < 4; k++) begin
            emit(memWord(ldrOpc, 1, 7, 8 + k));
            emit(memWord(strOpc, 1, 7, -1 - k));
            emit(memWord(ldrOpc, 2, 7, -1 - k));
            emit(memWord(strOpc, 2, 6, 15 - k));
            emit(memWord(ldrOpc, 3, 6, 15 - k));
            emit(memWord(strOpc, 3, 6, k - 16));
        end
        emit(haltWord);
    endtask

    task automatic buildBranches();
        newProgram();
        for (int p = 0; p < 8; p++) begin
            image[baseB - 16 + 2 * p] = wordT'($random(seed));
            image[baseB - 15 + 2 * p] = wordT'($random(seed));
        end
        // equal, overflow on both sides, off by one
        image[baseB - 15] = image[baseB - 16];
        image[baseB - 14] = 16'h7FFF;
        image[baseB - 13] = 16'hFFFF;
        image[baseB - 12] = 16'h8000;
        image[baseB - 11] = 16'h0001;
        image[baseB - 9] = image[baseB - 10] + 1'b1;
        for (int p = 0; p < 8; p++) begin
            emit(memWord(ldrOpc, 1, 6, 2 * p - 16));
            emit(memWord(ldrOpc, 2, 6, 2 * p - 15));
            emit(aluWord(1, 0, 1, 0, 2));
            // marker c when taken, c + 8 when not
            for (int c = 0; c < 5; c++) begin
                emit(movImm(3, c));
                emit(branchWord(c, 1));
                emit(movImm(3, c + 8));
                emit(memWord(strOpc, 3, 7, p - 8));
            end
        end
        // forward over a store, back to it, then out
        emit(branchWord(0, 2));
        emit(memWord(strOpc, 1, 7, 15));
        emit(branchWord(0, 1));
        emit(branchWord(0, -3));
        emit(haltWord);
    endtask

    task automatic resetCore(input bit reload, input int limit);
        @(negedge clk);
        arstN = 1'b0;
        loadImage = reload;
        cycleLimit = limit;
        @(negedge clk);
        loadImage = 1'b0;
        repeat (2) @(negedge clk);
        arstN = 1'b1;
    endtask

    // halted then a quiet stretch for the bus monitor
    task automatic waitHalt();
        while (!halted) @(negedge clk);
        repeat (20) @(negedge clk);
    endtask

    task automatic checkFinal(input string name);
        assert (storeIdx == expCount)
        else reportMismatch($sformatf("%s: %0d stores, expected %0d", name, storeIdx, expCount));
        for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
            assert (mem[i] == modelMem[i])
            else reportMismatch($sformatf("%s: mem[%0h] is %h, expected %h",
                name, i, mem[i], modelMem[i]));
        end
        $display("%s: %0d stores checked", name, expCount);
    endtask

    function automatic int modelLimit();
        int steps;
        steps = runModel();
        return (steps > 0) ? steps * 12 + 100 : -1;
    endfunction

    task automatic runTest(input string name, input bit midReset);
        int limit;
        limit = modelLimit();
        assert (limit > 0) else begin
            $display("reference model of %s never reached HALT", name);
            stopRun();
        end
        resetCore(1'b1, limit);
        if (midReset) begin
            // memory keeps the early stores, the rerun rewrites them
            while (storeIdx < 3) @(negedge clk);
            resetCore(1'b0, limit);
        end
        waitHalt();
        checkFinal(name);
    endtask

    initial begin
        seed = 15;
        clk = 1'b0;
        arstN = 1'b0;
        loadImage = 1'b0;
        cycleLimit = 0;
        buildMoves();
        runTest("moves", 1'b0);
        buildAluOps();
        runTest("alu ops", 1'b0);
        buildMemOps();
        runTest("load store", 1'b0);
        buildBranches();
        runTest("branches", 1'b0);
        buildAluOps();
        runTest("reset mid-program", 1'b1);
        $display("sim passed");
        $finish;
    end

endmodule

/* cpuCore.f */
+incdir+design
+incdir+bench
design/cpuCorePkg.sv
design/instrDecoder.sv
design/controlFsm.sv
design/datapath.sv
design/pcUnit.sv
design/cpuCore.sv
bench/cpuCoreTb.sv

/* run.sh */
#!/bin/sh
# build and run the cpuCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f cpuCore.f --top-module cpuCoreTb -o cpuCoreSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cpuCoreSim > sim.log 2>&1
simStatus=$?
cat sim.log

# verdict comes from the log
if grep -q "sim failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

exit 0
